/* logic/mrd_plan_pkg.sv */
package mrd_plan_pkg;

	// -------------------------------------------------------------------------
	// widths
	// -------------------------------------------------------------------------

	// packet length and all counts
	localparam int PTS_W = 12;
	// one radix factor
	localparam int FACTOR_W = 3;
	// plan slots, one per radix stage
	localparam int MAX_STAGES = 6;
	// stage index and factor count
	localparam int STAGE_W = 3;

	// supported radices, 1 marks an empty slot
	typedef enum logic [FACTOR_W-1:0] {
		RADIX_1 = 3'd1,
		RADIX_2 = 3'd2,
		RADIX_3 = 3'd3,
		RADIX_4 = 3'd4,
		RADIX_5 = 3'd5
	} radix_e;

	// -------------------------------------------------------------------------
	// factor plan
	// -------------------------------------------------------------------------

	// slot 0 is the first stage
	typedef struct packed {
		logic [PTS_W-1:0]                     dftpts;
		logic [STAGE_W-1:0]                   num_factors;
		radix_e [0:MAX_STAGES-1]              nf;
		// butterflies per stage, N / nf
		logic [0:MAX_STAGES-1][PTS_W-1:0]     div_nf;
		// twiddle denominator, remainder before the stage
		logic [0:MAX_STAGES-1][PTS_W-1:0]     twdl;
		logic                                 unsupported;
	} mrd_plan_t;

endpackage

/* logic/mrd_bank_pkg.sv */
package mrd_bank_pkg;

	import mrd_plan_pkg::*;

	// apb bus widths
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// per bank sequence
	typedef enum logic [2:0] {
		IDLE,
		SINK,
		WAIT_PLAN,
		COMPUTE,
		WAIT_OUT,
		SOURCE
	} bank_state_e;

	// sink side pulses, dftpts valid with sop
	typedef struct packed {
		logic             sop;
		logic [PTS_W-1:0] dftpts;
		logic             done;
	} mrd_sink_t;

	// fsm to tracker
	typedef struct packed {
		logic      accept;
		logic      plan_valid;
		mrd_plan_t plan;
		logic      may_source;
	} mrd_bank_ctrl_t;

	// tracker to fsm
	typedef struct packed {
		bank_state_e        state;
		logic               sink_end;
		logic               source_start;
		logic               source_end;
		logic [STAGE_W-1:0] stage;
	} mrd_bank_stat_t;

	// sample index stream
	typedef struct packed {
		logic             valid;
		logic             bank;
		logic [PTS_W-1:0] index;
		logic             last;
	} mrd_source_t;

	// fsm view for the host registers
	typedef struct packed {
		mrd_plan_t   plan0;
		mrd_plan_t   plan1;
		logic        sw_in;
		logic        sw_out;
		bank_state_e state0;
		bank_state_e state1;
		logic        overflow;
		// one cycle after plan_done, bank plan already updated
		logic        plan_load;
		logic        plan_bank;
	} mrd_ctrl_info_t;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic              pready;
		logic              pslverr;
	} apb_rsp_t;

	// host register map
	typedef enum logic [APB_AW-1:0] {
		STATUS    = 8'h00,
		PLAN      = 8'h04,
		PKT_COUNT = 8'h08,
		CLEAR     = 8'h0C,
		TWDL0     = 8'h10,
		TWDL1     = 8'h14,
		TWDL2     = 8'h18,
		TWDL3     = 8'h1C,
		TWDL4     = 8'h20,
		TWDL5     = 8'h24
	} reg_addr_e;

endpackage

/* logic/mrd_factor_planner.sv */
`timescale 1ns/10ps

module mrd_factor_planner
	import mrd_plan_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  logic [PTS_W-1:0] dftpts,
	output logic             busy,
	output logic             plan_done,
	output mrd_plan_t        plan
);

	// remainder still to be factored
	logic [PTS_W-1:0]   rem;
	// slot filled on the next edge while busy
	logic [STAGE_W-1:0] step;
	logic [STAGE_W-1:0] slot;
	logic [PTS_W-1:0]   cur_rem;
	logic [PTS_W-1:0]   cur_pts;
	logic [PTS_W-1:0]   next_rem;
	radix_e             next_radix;

	// constant divisors only, no general divider
	function automatic logic [PTS_W-1:0] div_radix(input logic [PTS_W-1:0] val,
		input radix_e r);
		case (r)
			RADIX_2: return val >> 1;
			RADIX_3: return val / PTS_W'(3);
			RADIX_4: return val >> 2;
			RADIX_5: return val / PTS_W'(5);
			default: return val;
		endcase
	endfunction

	// -------------------------------------------------------------------------
	// one factorisation step
	// -------------------------------------------------------------------------

	// slot 0 is taken on the start edge itself
	assign cur_rem = start ? dftpts : rem;
	assign cur_pts = start ? dftpts : plan.dftpts;
	assign slot    = start ? '0 : step;

	// priority 4, 2, 5, 3
	always_comb begin
		if (cur_rem[1:0] == 2'b00)
			next_radix = RADIX_4;
		else if (cur_rem[0] == 1'b0)
			next_radix = RADIX_2;
		else if (cur_rem % PTS_W'(5) == '0)
			next_radix = RADIX_5;
		else if (cur_rem % PTS_W'(3) == '0)
			next_radix = RADIX_3;
		else
			next_radix = RADIX_1;
	end

	assign next_rem = div_radix(cur_rem, next_radix);

	// -------------------------------------------------------------------------
	// step control
	// -------------------------------------------------------------------------

	// start edge plus five more, done seen six cycles after start
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			step      <= '0;
			plan_done <= 1'b0;
		end else begin
			plan_done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= STAGE_W'(1);
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == STAGE_W'(MAX_STAGES - 1)) begin
					busy      <= 1'b0;
					plan_done <= 1'b1;
				end
			end
		end
	end

	// plan contents
	always_ff @(posedge clk) begin
		if (start || busy) begin
			rem               <= next_rem;
			plan.nf[slot]     <= next_radix;
			plan.div_nf[slot] <= div_radix(cur_pts, next_radix);
			plan.twdl[slot]   <= cur_rem;
		end
		if (start) begin
			plan.dftpts      <= dftpts;
			plan.num_factors <= (next_radix != RADIX_1) ? STAGE_W'(1) : '0;
			plan.unsupported <= 1'b0;
		end else if (busy) begin
			if (next_radix != RADIX_1)
				plan.num_factors <= plan.num_factors + 1'b1;
			// leftover prime above 5, or more than six factors
			if (step == STAGE_W'(MAX_STAGES - 1))
				plan.unsupported <= (next_rem != PTS_W'(1));
		end
	end

endmodule

/* logic/mrd_bank_tracker.sv */
`timescale 1ns/10ps

module mrd_bank_tracker
	import mrd_plan_pkg::*;
	import mrd_bank_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	input  logic           bank_id,
	input  mrd_sink_t      sink,
	input  mrd_bank_ctrl_t ctrl,
	input  logic           source_ready,
	output mrd_bank_stat_t stat,
	output mrd_source_t    source
);

	bank_state_e        state;
	logic [STAGE_W-1:0] stage;
	// butterfly cycles within the stage
	logic [PTS_W-1:0]   bfly_cnt;
	logic [PTS_W-1:0]   index;
	logic [PTS_W-1:0]   last_index;
	logic               no_compute;
	logic               stage_end;
	logic               last_stage;
	logic               last_beat;

	assign last_index = ctrl.plan.dftpts - 1'b1;
	// nothing to run for a bad plan
	assign no_compute = ctrl.plan.unsupported || (ctrl.plan.num_factors == '0);
	assign stage_end  = (bfly_cnt == ctrl.plan.div_nf[stage] - 1'b1);
	assign last_stage = (stage == ctrl.plan.num_factors - 1'b1);
	assign last_beat  = (index == last_index);

	// -------------------------------------------------------------------------
	// bank sequence
	// -------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			stage    <= '0;
			bfly_cnt <= '0;
			index    <= '0;
		end else begin
			case (state)
				IDLE:
					if (ctrl.accept && sink.sop)
						state <= SINK;
				SINK:
					if (sink.done)
						state <= WAIT_PLAN;
				WAIT_PLAN:
					if (ctrl.plan_valid) begin
						stage    <= '0;
						bfly_cnt <= '0;
						state    <= no_compute ? WAIT_OUT : COMPUTE;
					end
				COMPUTE:
					// stage k runs div_nf[k] cycles
					if (stage_end) begin
						bfly_cnt <= '0;
						if (last_stage)
							state <= WAIT_OUT;
						else
							stage <= stage + 1'b1;
					end else begin
						bfly_cnt <= bfly_cnt + 1'b1;
					end
				WAIT_OUT:
					if (ctrl.may_source) begin
						index <= '0;
						state <= SOURCE;
					end
				SOURCE:
					// hold index under back-pressure
					if (source_ready) begin
						if (last_beat)
							state <= IDLE;
						else
							index <= index + 1'b1;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	// status pulses
	assign stat.state        = state;
	assign stat.sink_end     = (state == SINK) && sink.done;
	assign stat.source_start = (state == WAIT_OUT) && ctrl.may_source;
	assign stat.source_end   = (state == SOURCE) && source_ready && last_beat;
	assign stat.stage        = stage;

	// zero when idle so the top can or both banks
	assign source.valid = (state == SOURCE);
	assign source.bank  = (state == SOURCE) && bank_id;
	assign source.index = (state == SOURCE) ? index : '0;
	assign source.last  = (state == SOURCE) && last_beat;

endmodule

/* logic/mrd_ctrl_fsm.sv */
`timescale 1ns/10ps

module mrd_ctrl_fsm
	import mrd_plan_pkg::*;
	import mrd_bank_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	input  mrd_sink_t      sink,
	input  mrd_bank_stat_t stat0,
	input  mrd_bank_stat_t stat1,
	input  logic           clear_overflow,
	output mrd_bank_ctrl_t ctrl0,
	output mrd_bank_ctrl_t ctrl1,
	output mrd_sink_t      bank_sink0,
	output mrd_sink_t      bank_sink1,
	output mrd_ctrl_info_t info,
	output logic           overflow
);

	// ping-pong pointers for sink and source side
	logic      sw_in;
	logic      sw_out;
	logic      sink_busy;
	logic      target_idle;
	logic      plan_start;
	logic      plan_busy;
	logic      plan_done;
	// bank the running plan belongs to
	logic      plan_bank;
	logic      load_bank;
	logic      plan_load;
	logic      plan_valid0;
	logic      plan_valid1;
	mrd_plan_t new_plan;
	mrd_plan_t plan0;
	mrd_plan_t plan1;

	// -------------------------------------------------------------------------
	// sink acceptance
	// -------------------------------------------------------------------------

	assign sink_busy   = (stat0.state == SINK) || (stat1.state == SINK);
	assign target_idle = sw_in ? (stat1.state == IDLE) : (stat0.state == IDLE);
	// accept and planner start in the same cycle
	assign plan_start  = sink.sop && target_idle && !sink_busy && !plan_busy;

	mrd_factor_planner u_planner (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (plan_start),
		.dftpts    (sink.dftpts),
		.busy      (plan_busy),
		.plan_done (plan_done),
		.plan      (new_plan)
	);

	always_comb begin
		ctrl0.accept      = plan_start && !sw_in;
		ctrl0.plan_valid  = plan_valid0;
		ctrl0.plan        = plan0;
		// source grant follows arrival order
		ctrl0.may_source  = !sw_out;
		ctrl1.accept      = plan_start && sw_in;
		ctrl1.plan_valid  = plan_valid1;
		ctrl1.plan        = plan1;
		ctrl1.may_source  = sw_out;
		// done only to the bank that is sinking
		bank_sink0.sop    = plan_start && !sw_in;
		bank_sink0.dftpts = sink.dftpts;
		bank_sink0.done   = sink.done && (stat0.state == SINK);
		bank_sink1.sop    = plan_start && sw_in;
		bank_sink1.dftpts = sink.dftpts;
		bank_sink1.done   = sink.done && (stat1.state == SINK);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sw_in       <= 1'b0;
			sw_out      <= 1'b0;
			overflow    <= 1'b0;
			plan_bank   <= 1'b0;
			load_bank   <= 1'b0;
			plan_load   <= 1'b0;
			plan_valid0 <= 1'b0;
			plan_valid1 <= 1'b0;
		end else begin
			if (stat0.sink_end || stat1.sink_end)
				sw_in <= !sw_in;
			if (stat0.source_end || stat1.source_end)
				sw_out <= !sw_out;
			// dropped sop wins over a clear
			if (sink.sop && !plan_start)
				overflow <= 1'b1;
			else if (clear_overflow)
				overflow <= 1'b0;
			if (plan_start)
				plan_bank <= sw_in;
			plan_load <= plan_done;
			if (plan_done)
				load_bank <= plan_bank;
			// plan stays valid until the bank has sourced
			if (stat0.source_end)
				plan_valid0 <= 1'b0;
			if (stat1.source_end)
				plan_valid1 <= 1'b0;
			if (plan_done && !plan_bank)
				plan_valid0 <= 1'b1;
			if (plan_done && plan_bank)
				plan_valid1 <= 1'b1;
		end
	end

	// per bank plan store
	always_ff @(posedge clk) begin
		if (plan_done && !plan_bank)
			plan0 <= new_plan;
		if (plan_done && plan_bank)
			plan1 <= new_plan;
	end

	always_comb begin
		info.plan0     = plan0;
		info.plan1     = plan1;
		info.sw_in     = sw_in;
		info.sw_out    = sw_out;
		info.state0    = stat0.state;
		info.state1    = stat1.state;
		info.overflow  = overflow;
		info.plan_load = plan_load;
		info.plan_bank = load_bank;
	end

endmodule

/* logic/mrd_apb_regs.sv */
`timescale 1ns/10ps

module mrd_apb_regs
	import mrd_plan_pkg::*;
	import mrd_bank_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	input  apb_req_t       apb,
	input  mrd_ctrl_info_t info,
	input  logic           source_end_any,
	output apb_rsp_t       apb_rsp,
	output logic           clear_overflow
);

	// access phase of a transfer
	logic              access;
	logic              mapped;
	reg_addr_e         addr;
	logic [APB_DW-1:0] rdata;
	logic [APB_DW-1:0] pkt_count;
	// most recently finished plan
	mrd_plan_t         last_plan;

	assign access = apb.psel && apb.penable;
	assign addr   = reg_addr_e'(apb.paddr);

	// -------------------------------------------------------------------------
	// read decode
	// -------------------------------------------------------------------------

	always_comb begin
		rdata  = '0;
		mapped = 1'b1;
		case (addr)
			STATUS:
				rdata[8:0] = {info.overflow, info.state1, info.state0, info.sw_out, info.sw_in};
			PLAN: begin
				rdata[STAGE_W-1:0] = last_plan.num_factors;
				// nf slot 0 in the low field
				for (int i = 0; i < MAX_STAGES; i++)
					rdata[STAGE_W + FACTOR_W*i +: FACTOR_W] = last_plan.nf[i];
				rdata[STAGE_W + FACTOR_W*MAX_STAGES] = last_plan.unsupported;
			end
			PKT_COUNT:
				rdata = pkt_count;
			// write only, reads as zero
			CLEAR:
				rdata = '0;
			TWDL0:
				rdata[PTS_W-1:0] = last_plan.twdl[0];
			TWDL1:
				rdata[PTS_W-1:0] = last_plan.twdl[1];
			TWDL2:
				rdata[PTS_W-1:0] = last_plan.twdl[2];
			TWDL3:
				rdata[PTS_W-1:0] = last_plan.twdl[3];
			TWDL4:
				rdata[PTS_W-1:0] = last_plan.twdl[4];
			TWDL5:
				rdata[PTS_W-1:0] = last_plan.twdl[5];
			default:
				mapped = 1'b0;
		endcase
	end

	// no wait states
	assign apb_rsp.prdata  = (access && !apb.pwrite) ? rdata : '0;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = access && !mapped;

	// write 1 to bit 0
	assign clear_overflow = access && apb.pwrite && (addr == CLEAR) && apb.pwdata[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_count <= '0;
			last_plan <= '0;
		end else begin
			if (source_end_any)
				pkt_count <= pkt_count + 1'b1;
			if (info.plan_load)
				last_plan <= info.plan_bank ? info.plan1 : info.plan0;
		end
	end

endmodule

/* logic/mrd_ctrl_top.sv */
`timescale 1ns/10ps

module mrd_ctrl_top
	import mrd_bank_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  mrd_sink_t   sink,
	input  logic        source_ready,
	input  apb_req_t    apb,
	output mrd_source_t source,
	output apb_rsp_t    apb_rsp,
	output logic        overflow
);

	mrd_bank_ctrl_t ctrl0;
	mrd_bank_ctrl_t ctrl1;
	mrd_bank_stat_t stat0;
	mrd_bank_stat_t stat1;
	mrd_sink_t      bank_sink0;
	mrd_sink_t      bank_sink1;
	mrd_source_t    source0;
	mrd_source_t    source1;
	mrd_ctrl_info_t info;
	logic           clear_overflow;
	logic           source_end_any;

	// -------------------------------------------------------------------------
	// control
	// -------------------------------------------------------------------------

	mrd_ctrl_fsm u_ctrl_fsm (
		.clk            (clk),
		.rst_n          (rst_n),
		.sink           (sink),
		.stat0          (stat0),
		.stat1          (stat1),
		.clear_overflow (clear_overflow),
		.ctrl0          (ctrl0),
		.ctrl1          (ctrl1),
		.bank_sink0     (bank_sink0),
		.bank_sink1     (bank_sink1),
		.info           (info),
		.overflow       (overflow)
	);

	// ping bank
	mrd_bank_tracker u_bank0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.bank_id      (1'b0),
		.sink         (bank_sink0),
		.ctrl         (ctrl0),
		.source_ready (source_ready),
		.stat         (stat0),
		.source       (source0)
	);

	// pong bank
	mrd_bank_tracker u_bank1 (
		.clk          (clk),
		.rst_n        (rst_n),
		.bank_id      (1'b1),
		.sink         (bank_sink1),
		.ctrl         (ctrl1),
		.source_ready (source_ready),
		.stat         (stat1),
		.source       (source1)
	);

	// only the sw_out bank drives a nonzero source
	assign source         = source0 | source1;
	assign source_end_any = stat0.source_end || stat1.source_end;

	mrd_apb_regs u_apb_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.apb            (apb),
		.info           (info),
		.source_end_any (source_end_any),
		.apb_rsp        (apb_rsp),
		.clear_overflow (clear_overflow)
	);

endmodule

/* test/mrd_ctrl_props.sv */
`timescale 1ns/10ps

module mrd_ctrl_props
	import mrd_plan_pkg::*;
	import mrd_bank_pkg::*;
(
	input logic           clk,
	input logic           rst_n,
	input mrd_bank_stat_t stat0,
	input mrd_bank_stat_t stat1,
	input mrd_bank_ctrl_t ctrl0,
	input mrd_bank_ctrl_t ctrl1,
	input logic           sw_out,
	input logic           plan_start
);

	// -------------------------------------------------------------------------
	// control rules
	// -------------------------------------------------------------------------

	// a bank only takes a packet from IDLE
	a_accept_idle0: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl0.accept |-> (stat0.state == IDLE))
		else $error("accept to bank 0 while not idle");
	a_accept_idle1: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl1.accept |-> (stat1.state == IDLE))
		else $error("accept to bank 1 while not idle");

	// one bank starts its source at a time
	a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
		!(stat0.source_start && stat1.source_start))
		else $error("both banks started a source in one cycle");

	// output pointer moves only after a finished source
	a_sw_out: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(sw_out) |-> $past(stat0.source_end || stat1.source_end))
		else $error("sw_out toggled without source_end");

	// no new start in the five busy cycles after a start
	a_plan_start: assert property (@(posedge clk) disable iff (!rst_n)
		plan_start |-> !($past(plan_start, 1) || $past(plan_start, 2)
			|| $past(plan_start, 3) || $past(plan_start, 4) || $past(plan_start, 5)))
		else $error("planner started while busy");

endmodule

bind mrd_ctrl_fsm mrd_ctrl_props u_ctrl_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.stat0      (stat0),
	.stat1      (stat1),
	.ctrl0      (ctrl0),
	.ctrl1      (ctrl1),
	.sw_out     (sw_out),
	.plan_start (plan_start)
);

/* test/mrd_ctrl_tb.sv */
`timescale 1ns/10ps

module mrd_ctrl_tb
	import mrd_plan_pkg::*;
	import mrd_bank_pkg::*;
();

	localparam int NUM_ROWS = 7;

	// one packet per row, nf in slot order
	typedef struct packed {
		logic [PTS_W-1:0]                  n;
		logic [7:0]                        gap;
		logic [7:0]                        sink_len;
		logic [STAGE_W-1:0]                nfac;
		logic [0:MAX_STAGES-1][FACTOR_W-1:0] nf;
		logic                              unsup;
		// extra sop, 1 in the middle of the sink, 2 while both banks hold a packet
		logic [1:0]                        inject;
	} row_t;

	logic        clk;
	logic        rst_n;
	mrd_sink_t   sink;
	logic        source_ready;
	apb_req_t    apb;
	mrd_source_t source;
	apb_rsp_t    apb_rsp;
	logic        overflow;

	row_t        rows [NUM_ROWS];
	logic [15:0] lfsr_state;
	int          err_count = 0;
	// packets fully sourced, and their lengths still to come
	int          done_count = 0;
	int          n_q [$];
	int          exp_idx = 0;

	mrd_ctrl_top u_mrd_ctrl_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.sink         (sink),
		.source_ready (source_ready),
		.apb          (apb),
		.source       (source),
		.apb_rsp      (apb_rsp),
		.overflow     (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// -------------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------------

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic fail_run(input string msg);
		err_count++;
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_source(input mrd_source_t exp, input mrd_source_t act);
		if (exp !== act)
			fail_run($sformatf("CHECK FAILED t=%0t signal=source expected=%h actual=%h",
				$time, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act)
			fail_run($sformatf("CHECK FAILED t=%0t signal=%s expected=%b actual=%b",
				$time, name, exp, act));
	endtask

	task automatic check_apb(input string name, input logic [APB_DW-1:0] exp,
		input logic [APB_DW-1:0] act);
		if (exp !== act)
			fail_run($sformatf("CHECK FAILED t=%0t signal=%s expected=%h actual=%h",
				$time, name, exp, act));
	endtask

	// fields the host can see
	task automatic check_plan(input mrd_plan_t exp, input mrd_plan_t act);
		check_apb("plan.num_factors", APB_DW'(exp.num_factors), APB_DW'(act.num_factors));
		check_flag("plan.unsupported", exp.unsupported, act.unsupported);
		for (int i = 0; i < MAX_STAGES; i++) begin
			check_apb($sformatf("plan.nf[%0d]", i), APB_DW'(exp.nf[i]), APB_DW'(act.nf[i]));
			check_apb($sformatf("plan.twdl[%0d]", i), APB_DW'(exp.twdl[i]),
				APB_DW'(act.twdl[i]));
		end
	endtask

	// twdl is the remainder before each stage
	function automatic mrd_plan_t expected_plan(input row_t r);
		mrd_plan_t        p;
		logic [PTS_W-1:0] rem;
		p = '0;
		rem = r.n;
		p.dftpts = r.n;
		p.num_factors = r.nfac;
		p.unsupported = r.unsup;
		for (int k = 0; k < MAX_STAGES; k++) begin
			p.nf[k] = radix_e'(r.nf[k]);
			p.div_nf[k] = r.n / PTS_W'(r.nf[k]);
			p.twdl[k] = rem;
			rem = rem / PTS_W'(r.nf[k]);
		end
		return p;
	endfunction

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
		output logic err);
		@(posedge clk);
		apb <= '{1'b1, 1'b0, 1'b0, addr, APB_DW'(0)};
		@(posedge clk);
		apb.penable <= 1'b1;
		@(negedge clk);
		data = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		// no wait states
		check_flag("pready", 1'b1, apb_rsp.pready);
		@(posedge clk);
		apb <= '0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
		@(posedge clk);
		apb <= '{1'b1, 1'b0, 1'b1, addr, data};
		@(posedge clk);
		apb.penable <= 1'b1;
		@(posedge clk);
		apb <= '0;
	endtask

	// -------------------------------------------------------------------------
	// back-pressure and source monitor
	// -------------------------------------------------------------------------

	initial begin
		source_ready = 1'b0;
		lfsr_state = 16'h0001;
		forever begin
			@(posedge clk);
			lfsr_state = lfsr_next(lfsr_state);
			source_ready <= lfsr_state[0];
		end
	end

	// ready seen here is what the next edge uses
	always @(negedge clk) begin
		mrd_source_t exp;
		if (rst_n && source.valid) begin
			if (n_q.size() == 0)
				fail_run("source valid with no accepted packet pending");
			exp.valid = 1'b1;
			exp.bank = done_count[0];
			exp.index = PTS_W'(exp_idx);
			exp.last = (exp_idx == n_q[0] - 1);
			check_source(exp, source);
			if (source_ready) begin
				if (exp.last) begin
					void'(n_q.pop_front());
					exp_idx = 0;
					done_count++;
				end else begin
					exp_idx++;
				end
			end
		end
	end

	// limit from the table, waits until it is filled
	initial begin
		int limit;
		limit = 600;
		wait (rst_n === 1'b1);
		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += rows[r].gap + rows[r].sink_len + 6 + 2 * rows[r].n;
			if (!rows[r].unsup)
				for (int k = 0; k < rows[r].nfac; k++)
					limit += rows[r].n / rows[r].nf[k];
		end
		repeat (limit) @(posedge clk);
		fail_run($sformatf("timeout after %0d cycles, packets done %0d", limit, done_count));
	end

	// -------------------------------------------------------------------------
	// main sequence
	// -------------------------------------------------------------------------

	initial begin
		logic [APB_DW-1:0] rd;
		logic              err;
		mrd_plan_t         act;
		rst_n = 1'b0;
		sink = '0;
		apb = '0;
		rows[0] = '{12'd12, 8'd2, 8'd5, 3'd2, {3'd4, 3'd3, 3'd1, 3'd1, 3'd1, 3'd1}, 1'b0, 2'd0};
		rows[1] = '{12'd24, 8'd0, 8'd8, 3'd3, {3'd4, 3'd2, 3'd3, 3'd1, 3'd1, 3'd1}, 1'b0, 2'd1};
		rows[2] = '{12'd60, 8'd3, 8'd4, 3'd3, {3'd4, 3'd5, 3'd3, 3'd1, 3'd1, 3'd1}, 1'b0, 2'd0};
		rows[3] = '{12'd180, 8'd1, 8'd10, 3'd4, {3'd4, 3'd5, 3'd3, 3'd3, 3'd1, 3'd1}, 1'b0, 2'd0};
		rows[4] = '{12'd972, 8'd4, 8'd6, 3'd6, {3'd4, 3'd3, 3'd3, 3'd3, 3'd3, 3'd3}, 1'b0, 2'd0};
		rows[5] = '{12'd1200, 8'd2, 8'd12, 3'd5, {3'd4, 3'd4, 3'd5, 3'd5, 3'd3, 3'd1}, 1'b0, 2'd2};
		// prime above 5, still sourced
		rows[6] = '{12'd7, 8'd1, 8'd3, 3'd0, {3'd1, 3'd1, 3'd1, 3'd1, 3'd1, 3'd1}, 1'b1, 2'd0};
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// reset values
		@(negedge clk);
		check_flag("source.valid", 1'b0, source.valid);
		check_flag("overflow", 1'b0, overflow);
		apb_read(STATUS, rd, err);
		check_apb("STATUS", '0, rd);
		check_flag("pslverr", 1'b0, err);
		apb_read(8'h30, rd, err);
		check_flag("pslverr", 1'b1, err);

		for (int r = 0; r < NUM_ROWS; r++) begin
			// this bank is free once the packet two rows back has left
			while (done_count < r - 1)
				@(posedge clk);
			repeat (rows[r].gap) @(posedge clk);
			@(posedge clk);
			sink <= '{1'b1, rows[r].n, 1'b0};
			n_q.push_back(int'(rows[r].n));
			// sample stream, optionally with a sop that must be dropped
			for (int j = 0; j < rows[r].sink_len; j++) begin
				@(posedge clk);
				if (rows[r].inject == 2'd1 && j == 1)
					sink <= '{1'b1, 12'd99, 1'b0};
				else
					sink <= '0;
			end
			@(posedge clk);
			sink <= '{1'b0, '0, 1'b1};
			@(posedge clk);
			sink <= '0;

			// planner result reaches the host registers
			repeat (MAX_STAGES) @(posedge clk);

			// plan registers of this packet
			act = '0;
			apb_read(PLAN, rd, err);
			act.num_factors = rd[STAGE_W-1:0];
			for (int i = 0; i < MAX_STAGES; i++)
				act.nf[i] = radix_e'(rd[STAGE_W + FACTOR_W*i +: FACTOR_W]);
			act.unsupported = rd[STAGE_W + FACTOR_W*MAX_STAGES];
			for (int i = 0; i < MAX_STAGES; i++) begin
				apb_read(APB_AW'(8'h10 + 4 * i), rd, err);
				act.twdl[i] = rd[PTS_W-1:0];
			end
			check_plan(expected_plan(rows[r]), act);

			if (rows[r].inject == 2'd2) begin
				// previous packet still in the other bank
				@(posedge clk);
				sink <= '{1'b1, 12'd99, 1'b0};
				@(posedge clk);
				sink <= '0;
			end

			if (rows[r].inject != 2'd0) begin
				@(negedge clk);
				check_flag("overflow", 1'b1, overflow);
				apb_read(STATUS, rd, err);
				check_flag("STATUS.overflow", 1'b1, rd[8]);
				apb_write(CLEAR, 32'd1);
				@(negedge clk);
				check_flag("overflow", 1'b0, overflow);
				apb_read(STATUS, rd, err);
				check_flag("STATUS.overflow", 1'b0, rd[8]);
			end
		end

		// every accepted packet has left
		while (done_count < NUM_ROWS)
			@(posedge clk);
		apb_read(PKT_COUNT, rd, err);
		check_apb("PKT_COUNT", APB_DW'(NUM_ROWS), rd);

		if (err_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			fail_run("errors seen during the run");
		end
	end

endmodule

/* mrd_ctrl.f */
logic/mrd_plan_pkg.sv
logic/mrd_bank_pkg.sv
logic/mrd_factor_planner.sv
logic/mrd_bank_tracker.sv
logic/mrd_ctrl_fsm.sv
logic/mrd_apb_regs.sv
logic/mrd_ctrl_top.sv
test/mrd_ctrl_props.sv
test/mrd_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mrd_ctrl testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module mrd_ctrl_tb \
	-f mrd_ctrl.f \
	-Mdir obj_dir

# the simulation exits nonzero on a fatal check, keep going to the search
output=$(./obj_dir/Vmrd_ctrl_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
else
	exit 1
fi
